//--- cache_pkg.sv
package cache_pkg;

    localparam int offset_bits = 5;     // byte offset in a 32-byte line
    localparam int words_per_line = 8;

    typedef logic [words_per_line*32-1:0] line_t;

    typedef enum logic {
        mem_read,
        mem_write
    } mem_op_e;

    // one whole-line transfer on a four-phase link
    typedef struct packed {
        mem_op_e op;
        logic [31:0] line_addr;     // offset bits are zero
        line_t wr_line;
    } mem_req_t;

    typedef struct packed {
        logic write;
        logic [31:0] addr;
        logic [3:0] strb;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef enum logic [1:0] {
        dc_lookup,
        dc_writeback,
        dc_refill,
        dc_respond
    } dcache_state_e;

    typedef enum logic [1:0] {
        ic_lookup,
        ic_refill,
        ic_respond
    } icache_state_e;

endpackage

//--- cache_top.f
cache_pkg.sv
line_ram.sv
dcache.sv
icache.sv
mem_arbiter.sv
cache_top.sv
tb_clock.sv
cache_top_tb.sv

//--- cache_top.sv
`timescale 1ns/1ps

module cache_top #(
    parameter int index_bits = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic d_valid,
    input  cache_pkg::cpu_req_t d_req,
    output logic d_addr_ok,
    output logic d_data_ok,
    output logic [31:0] d_rdata,
    input  logic i_valid,
    input  logic [31:0] i_addr,
    output logic i_addr_ok,
    output logic i_data_ok,
    output logic [31:0] i_rdata,
    output logic mem_req_valid,
    output cache_pkg::mem_req_t mem_req,
    input  logic mem_ack,
    input  cache_pkg::line_t mem_rdata
);

    cache_pkg::mem_req_t dc_req, ic_req;
    cache_pkg::line_t link_rdata;   // shared refill bus
    logic dc_req_valid, dc_ack, ic_req_valid, ic_ack;

    dcache #(.index_bits(index_bits)) u_dcache (
        .clk(clk), .reset(reset), .d_valid(d_valid), .d_req(d_req),
        .d_addr_ok(d_addr_ok), .d_data_ok(d_data_ok), .d_rdata(d_rdata),
        .mem_req_valid(dc_req_valid), .mem_req(dc_req), .mem_ack(dc_ack),
        .mem_rdata(link_rdata)
    );

    icache #(.index_bits(index_bits)) u_icache (
        .clk(clk), .reset(reset), .i_valid(i_valid), .i_addr(i_addr),
        .i_addr_ok(i_addr_ok), .i_data_ok(i_data_ok), .i_rdata(i_rdata),
        .mem_req_valid(ic_req_valid), .mem_req(ic_req), .mem_ack(ic_ack),
        .mem_rdata(link_rdata)
    );

    mem_arbiter u_arbiter (
        .clk(clk), .reset(reset),
        .d_req_valid(dc_req_valid), .d_req(dc_req), .d_ack(dc_ack),
        .i_req_valid(ic_req_valid), .i_req(ic_req), .i_ack(ic_ack),
        .rdata(link_rdata), .mem_req_valid(mem_req_valid), .mem_req(mem_req),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

endmodule

//--- cache_top_tb.sv
`timescale 1ns/1ps

module cache_top_tb;

    localparam int rand_ops = 40;
    localparam int n_ops = 40 + rand_ops * 2;   // directed plus random data and fetch
    localparam logic [31:0] fill_key = 32'h5eed_c0de;

    typedef struct packed {
        logic [31:0] data;
        logic [31:0] acc;       // cycle of acceptance
        logic must_hit;
        logic [31:0] reqs;      // memory requests seen at acceptance
    } pending_t;

    logic clk, reset;
    logic d_valid, d_addr_ok, d_data_ok, i_valid, i_addr_ok, i_data_ok;
    logic mem_req_valid, mem_ack, hits_only;
    logic prev_valid = 1'b0;
    logic [31:0] d_rdata, i_addr, i_rdata;
    logic [31:0] lfsr = 32'ha0de_62ff;
    cache_pkg::cpu_req_t d_req;
    cache_pkg::mem_req_t mem_req;
    cache_pkg::mem_req_t prev_req = '0;
    cache_pkg::line_t mem_rdata;
    logic [31:0] mem_model [logic [31:0]];
    logic [31:0] shadow [logic [31:0]];
    pending_t d_pend[$], i_pend[$], d_head, i_head;
    int cycle, reqs_seen, writes_seen, wb_before, checks, value_errors, protocol_errors;

    tb_clock clock_gen (.clk(clk), .reset(reset));

    cache_top #(.index_bits(4)) UUT (.*);

    function automatic logic [31:0] init_word(logic [31:0] addr);
        return addr ^ fill_key;
    endfunction

    function automatic logic [31:0] shadow_word(logic [31:0] addr);
        return shadow.exists(addr) ? shadow[addr] : init_word(addr);
    endfunction

    function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [3:0] strb,
                                                logic [31:0] wdata);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) r[b*8 +: 8] = wdata[b*8 +: 8];
        end
        return r;
    endfunction

    // galois lfsr with taps x^32+x^22+x^2+x+1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        assert (got === exp) else begin
            value_errors++;
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_rule(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            protocol_errors++;
            $display("protocol error at %0t ns: %s", $time, what);
        end
    endtask

    task automatic report_counts();
        $display("checks %0d, value errors %0d, protocol errors %0d, open requests %0d",
                 checks, value_errors, protocol_errors, d_pend.size() + i_pend.size());
    endtask

    task automatic d_access(input logic wr, input logic [31:0] addr, input logic [3:0] strb,
                            input logic [31:0] wdata);
        d_valid = 1'b1;
        d_req = '{write: wr, addr: addr, strb: strb, wdata: wdata};
        @(negedge clk);
        while (!d_addr_ok) @(negedge clk);
        @(posedge clk);
        #1;
        d_valid = 1'b0;
    endtask

    task automatic i_fetch(input logic [31:0] addr);
        i_valid = 1'b1;
        i_addr = addr;
        @(negedge clk);
        while (!i_addr_ok) @(negedge clk);
        @(posedge clk);
        #1;
        i_valid = 1'b0;
    endtask

    task automatic drain();
        while (d_pend.size() != 0 || i_pend.size() != 0 || mem_req_valid || mem_ack) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    // one line transfer with write data checked against the shadow copy
    task automatic serve(input cache_pkg::mem_req_t r);
        logic [31:0] a;
        for (int w = 0; w < cache_pkg::words_per_line; w++) begin
            a = r.line_addr + w * 4;
            if (r.op == cache_pkg::mem_write) begin
                check_value(r.wr_line[w*32 +: 32], shadow_word(a), "written-back word");
                mem_model[a] = r.wr_line[w*32 +: 32];
            end else begin
                mem_rdata[w*32 +: 32] = mem_model.exists(a) ? mem_model[a] : init_word(a);
            end
        end
        if (r.op == cache_pkg::mem_write) writes_seen++;
    endtask

    always @(posedge clk) cycle <= cycle + 1;

    initial begin
        mem_ack = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (mem_req_valid && !reset) begin
                repeat (rand_bits(3)) @(negedge clk);
                @(posedge clk);
                #1;
                serve(mem_req);
                mem_ack = 1'b1;
                @(negedge clk);
                while (mem_req_valid) @(negedge clk);
                @(posedge clk);
                #1;
                mem_ack = 1'b0;
            end
        end
    end

    // memory port rules and both cpu ports in order
    always @(negedge clk) begin
        if (!reset) begin
            if (mem_req_valid && !prev_valid) begin
                reqs_seen++;
                check_rule(!mem_ack, "mem_req_valid rose while mem_ack was high");
            end
            if (mem_req_valid && prev_valid)
                check_rule(mem_req === prev_req, "mem_req changed while mem_req_valid was high");
            if (prev_valid && !mem_req_valid)
                check_rule(mem_ack, "mem_req_valid dropped before mem_ack");
            if (d_data_ok) begin
                check_rule(d_pend.size() != 0, "d_data_ok without an accepted request");
                if (d_pend.size() != 0) begin
                    d_head = d_pend.pop_front();
                    check_value(d_rdata, d_head.data, "data port read");
                    if (d_head.must_hit) begin
                        check_rule(cycle - d_head.acc == 1, "hit not answered one cycle later");
                        check_rule(reqs_seen == d_head.reqs, "memory request during a hit");
                    end
                end
            end else if (d_pend.size() != 0 && cycle - d_pend[0].acc >= 1) begin
                check_rule(!d_addr_ok, "d_addr_ok high while dcache waits for memory");
            end
            if (d_valid && d_addr_ok) begin
                d_head = '{data: shadow_word(d_req.addr), acc: cycle, must_hit: hits_only,
                           reqs: reqs_seen};
                if (d_req.write) begin
                    d_head.data = merge_bytes(d_head.data, d_req.strb, d_req.wdata);
                    shadow[d_req.addr] = d_head.data;
                end
                d_pend.push_back(d_head);
            end
            if (i_data_ok) begin
                check_rule(i_pend.size() != 0, "i_data_ok without an accepted fetch");
                if (i_pend.size() != 0) begin
                    i_head = i_pend.pop_front();
                    check_value(i_rdata, i_head.data, "instruction fetch");
                end
            end else if (i_pend.size() != 0 && cycle - i_pend[0].acc >= 1) begin
                check_rule(!i_addr_ok, "i_addr_ok high while icache waits for memory");
            end
            if (i_valid && i_addr_ok) begin
                i_head = '{data: shadow_word(i_addr), acc: cycle, must_hit: 1'b0,
                           reqs: reqs_seen};
                i_pend.push_back(i_head);
            end
        end
        prev_valid = mem_req_valid;
        prev_req = mem_req;
    end

    initial begin
        repeat (n_ops * 64) @(posedge clk);
        $display("timeout: run not finished after %0d cycles", n_ops * 64);
        report_counts();
        $display("Test failed");
        $finish;
    end

    initial begin
        d_valid = 1'b0;
        d_req = '0;
        i_valid = 1'b0;
        i_addr = '0;
        hits_only = 1'b0;
        @(negedge reset);
        @(negedge clk);
        check_rule(!d_addr_ok && !d_data_ok && !i_addr_ok && !i_data_ok && !mem_req_valid,
                   "cache outputs not low after reset");
        @(posedge clk);
        #1;
        d_access(1'b0, 32'h100, 4'h0, 32'h0);      // cold miss
        drain();
        hits_only = 1'b1;
        for (int w = 0; w < 8; w++) d_access(1'b0, 32'h100 + w * 4, 4'h0, 32'h0);
        d_access(1'b1, 32'h104, 4'b0101, 32'haabb_ccdd);
        d_access(1'b1, 32'h108, 4'b1000, 32'h1122_3344);
        d_access(1'b1, 32'h104, 4'b0010, 32'h5566_7788);
        d_access(1'b0, 32'h104, 4'h0, 32'h0);
        d_access(1'b0, 32'h108, 4'h0, 32'h0);
        drain();
        hits_only = 1'b0;
        d_access(1'b1, 32'h140, 4'b0011, 32'hdead_beef);   // write miss
        d_access(1'b0, 32'h140, 4'h0, 32'h0);
        drain();
        // fill the other way of set 8 and push both dirty lines out
        wb_before = writes_seen;
        d_access(1'b1, 32'h304, 4'hf, 32'hcafe_0304);
        d_access(1'b0, 32'h500, 4'h0, 32'h0);
        d_access(1'b0, 32'h104, 4'h0, 32'h0);
        drain();
        check_rule(writes_seen >= wb_before + 2, "dirty victims were not written back");
        fork
            for (int k = 0; k < 6; k++) d_access(k % 2 == 1, 32'h2000 + k * 32'h220, 4'hf, k);
            for (int k = 0; k < 6; k++) i_fetch(32'h1_0000 + k * 32'h24);
        join
        drain();
        fork
            for (int k = 0; k < rand_ops; k++) begin
                d_access(rand_bits(1), rand_bits(9) << 2, rand_bits(4), rand_bits(32));
                if (rand_bits(1)) begin
                    @(posedge clk);     // idle gap
                    #1;
                end
            end
            for (int k = 0; k < rand_ops; k++) i_fetch(32'h1_0000 | (rand_bits(9) << 2));
        join
        drain();
        report_counts();
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- dcache.sv
`timescale 1ns/1ps

module dcache #(
    parameter int index_bits = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic d_valid,
    input  cache_pkg::cpu_req_t d_req,
    output logic d_addr_ok,
    output logic d_data_ok,
    output logic [31:0] d_rdata,
    output logic mem_req_valid,
    output cache_pkg::mem_req_t mem_req,
    input  logic mem_ack,
    input  cache_pkg::line_t mem_rdata
);

    localparam int tag_bits = 32 - cache_pkg::offset_bits - index_bits;
    localparam int line_bytes = cache_pkg::words_per_line * 4;
    localparam int tag_bytes = (tag_bits + 8) / 8;
    localparam int sets = 1 << index_bits;

    cache_pkg::dcache_state_e state;
    cache_pkg::cpu_req_t req_q;
    cache_pkg::mem_req_t mem_req_q, miss_req;
    cache_pkg::line_t [1:0] data_rd, way_line;
    cache_pkg::line_t lookup_line, refill_line, wr_line, fwd_line;
    logic [1:0][tag_bits:0] tag_rd;
    logic [1:0][line_bytes-1:0] data_we;
    logic [1:0][sets-1:0] valid_q, dirty_q;
    logic [sets-1:0] lru_q;     // way to replace next
    logic [1:0] way_hit;
    logic pend_valid, ack_seen, ready, lookup_hit, lookup_miss, refill_we;
    logic hit_way, victim, victim_dirty, fwd_valid, fwd_way;
    logic [index_bits-1:0] idx, raddr;
    logic [tag_bits-1:0] tag;
    logic [cache_pkg::offset_bits-3:0] word;
    logic [31:0] resp_word;

    function automatic cache_pkg::line_t apply_write(cache_pkg::line_t line,
                                                     cache_pkg::cpu_req_t r);
        cache_pkg::line_t result;
        logic [cache_pkg::offset_bits-3:0] w;
        result = line;
        w = r.addr[cache_pkg::offset_bits-1:2];
        if (r.write) begin
            for (int b = 0; b < 4; b++) begin
                if (r.strb[b]) result[w*32 + b*8 +: 8] = r.wdata[b*8 +: 8];
            end
        end
        return result;
    endfunction

    assign raddr = d_req.addr[cache_pkg::offset_bits +: index_bits];
    assign idx = req_q.addr[cache_pkg::offset_bits +: index_bits];
    assign tag = req_q.addr[31 -: tag_bits];
    assign word = req_q.addr[cache_pkg::offset_bits-1:2];

    for (genvar w = 0; w < 2; w++) begin : g_way
        line_ram #(.index_bits(index_bits), .width($bits(cache_pkg::line_t))) data_ram (
            .clk(clk), .reset(reset), .we(data_we[w]), .waddr(idx),
            .wdata(wr_line), .raddr(raddr), .rdata(data_rd[w])
        );
        line_ram #(.index_bits(index_bits), .width(tag_bits + 1)) tag_ram (
            .clk(clk), .reset(reset), .we({tag_bytes{refill_we && victim == 1'(w)}}),
            .waddr(idx), .wdata({1'b1, tag}), .raddr(raddr), .rdata(tag_rd[w])
        );
        // a write hit in the previous cycle is not yet visible in the ram output
        assign way_line[w] = (fwd_valid && fwd_way == 1'(w)) ? fwd_line : data_rd[w];
        assign way_hit[w] = valid_q[w][idx] && tag_rd[w][tag_bits] &&
                            tag_rd[w][tag_bits-1:0] == tag;
        assign data_we[w] = (refill_we && victim == 1'(w)) ? {line_bytes{1'b1}} :
                            (lookup_hit && req_q.write && hit_way == 1'(w)) ?
                            (line_bytes'(req_q.strb) << (word * 4)) : '0;
    end

    assign hit_way = way_hit[1];
    assign victim = lru_q[idx];
    assign victim_dirty = dirty_q[victim][idx];
    assign lookup_hit = state == cache_pkg::dc_lookup && pend_valid && (|way_hit);
    assign lookup_miss = state == cache_pkg::dc_lookup && pend_valid && !(|way_hit);
    assign refill_we = state == cache_pkg::dc_refill && !ack_seen && mem_ack;
    assign lookup_line = apply_write(way_line[hit_way], req_q);
    assign refill_line = apply_write(mem_rdata, req_q);    // pending write merged in
    assign wr_line = (state == cache_pkg::dc_refill) ? refill_line : lookup_line;
    assign miss_req = '{op: cache_pkg::mem_read,
                        line_addr: {req_q.addr[31:cache_pkg::offset_bits],
                                    {cache_pkg::offset_bits{1'b0}}},
                        wr_line: '0};

    assign ready = (state == cache_pkg::dc_lookup && (!pend_valid || lookup_hit)) ||
                   state == cache_pkg::dc_respond;
    assign d_addr_ok = d_valid && ready;
    assign d_data_ok = lookup_hit || state == cache_pkg::dc_respond;
    assign d_rdata = (state == cache_pkg::dc_respond) ? resp_word : lookup_line[word*32 +: 32];
    assign mem_req_valid = (state == cache_pkg::dc_writeback ||
                            state == cache_pkg::dc_refill) && !ack_seen;
    assign mem_req = mem_req_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_pkg::dc_lookup;
            pend_valid <= 1'b0;
            ack_seen <= 1'b0;
            fwd_valid <= 1'b0;
            valid_q <= '0;
            dirty_q <= '0;
            lru_q <= '0;
        end else begin
            if (ready) pend_valid <= d_valid;
            fwd_valid <= d_addr_ok && lookup_hit && req_q.write && raddr == idx;
            case (state)
                cache_pkg::dc_lookup: begin
                    if (lookup_hit) begin
                        lru_q[idx] <= ~hit_way;
                        if (req_q.write) dirty_q[hit_way][idx] <= 1'b1;
                    end else if (lookup_miss) begin
                        state <= victim_dirty ? cache_pkg::dc_writeback : cache_pkg::dc_refill;
                    end
                end
                cache_pkg::dc_writeback: begin
                    if (!ack_seen) begin
                        ack_seen <= mem_ack;
                    end else if (!mem_ack) begin
                        ack_seen <= 1'b0;
                        state <= cache_pkg::dc_refill;
                    end
                end
                cache_pkg::dc_refill: begin
                    if (refill_we) begin
                        ack_seen <= 1'b1;
                        valid_q[victim][idx] <= 1'b1;
                        dirty_q[victim][idx] <= req_q.write;
                        lru_q[idx] <= ~victim;
                    end else if (ack_seen && !mem_ack) begin
                        ack_seen <= 1'b0;
                        state <= cache_pkg::dc_respond;
                    end
                end
                default: state <= cache_pkg::dc_lookup;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (d_addr_ok) req_q <= d_req;
        fwd_way <= hit_way;
        fwd_line <= lookup_line;
        if (refill_we) resp_word <= refill_line[word*32 +: 32];
        if (lookup_miss) begin
            if (victim_dirty) begin
                mem_req_q <= '{op: cache_pkg::mem_write,
                               line_addr: {tag_rd[victim][tag_bits-1:0], idx,
                                           {cache_pkg::offset_bits{1'b0}}},
                               wr_line: way_line[victim]};
            end else begin
                mem_req_q <= miss_req;
            end
        end else if (state == cache_pkg::dc_writeback && ack_seen && !mem_ack) begin
            mem_req_q <= miss_req;      // refill follows the writeback
        end
    end

endmodule

//--- icache.sv
`timescale 1ns/1ps

module icache #(
    parameter int index_bits = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic i_valid,
    input  logic [31:0] i_addr,
    output logic i_addr_ok,
    output logic i_data_ok,
    output logic [31:0] i_rdata,
    output logic mem_req_valid,
    output cache_pkg::mem_req_t mem_req,
    input  logic mem_ack,
    input  cache_pkg::line_t mem_rdata
);

    localparam int tag_bits = 32 - cache_pkg::offset_bits - index_bits;
    localparam int line_bytes = cache_pkg::words_per_line * 4;
    localparam int tag_bytes = (tag_bits + 8) / 8;

    cache_pkg::icache_state_e state;
    cache_pkg::line_t data_rd;
    logic [tag_bits:0] tag_rd;
    logic [(1 << index_bits)-1:0] valid_q;
    logic [31:0] addr_q, resp_word;
    logic [index_bits-1:0] idx;
    logic [cache_pkg::offset_bits-3:0] word;
    logic pend_valid, ack_seen, ready, hit, refill_we;

    assign idx = addr_q[cache_pkg::offset_bits +: index_bits];
    assign word = addr_q[cache_pkg::offset_bits-1:2];

    line_ram #(.index_bits(index_bits), .width($bits(cache_pkg::line_t))) data_ram (
        .clk(clk), .reset(reset), .we({line_bytes{refill_we}}), .waddr(idx),
        .wdata(mem_rdata), .raddr(i_addr[cache_pkg::offset_bits +: index_bits]),
        .rdata(data_rd)
    );
    line_ram #(.index_bits(index_bits), .width(tag_bits + 1)) tag_ram (
        .clk(clk), .reset(reset), .we({tag_bytes{refill_we}}), .waddr(idx),
        .wdata({1'b1, addr_q[31 -: tag_bits]}),
        .raddr(i_addr[cache_pkg::offset_bits +: index_bits]), .rdata(tag_rd)
    );

    assign hit = state == cache_pkg::ic_lookup && pend_valid && valid_q[idx] &&
                 tag_rd[tag_bits] && tag_rd[tag_bits-1:0] == addr_q[31 -: tag_bits];
    assign refill_we = state == cache_pkg::ic_refill && !ack_seen && mem_ack;
    assign ready = (state == cache_pkg::ic_lookup && (!pend_valid || hit)) ||
                   state == cache_pkg::ic_respond;
    assign i_addr_ok = i_valid && ready;
    assign i_data_ok = hit || state == cache_pkg::ic_respond;
    assign i_rdata = (state == cache_pkg::ic_respond) ? resp_word : data_rd[word*32 +: 32];
    assign mem_req_valid = state == cache_pkg::ic_refill && !ack_seen;
    assign mem_req = '{op: cache_pkg::mem_read,
                       line_addr: {addr_q[31:cache_pkg::offset_bits],
                                   {cache_pkg::offset_bits{1'b0}}},
                       wr_line: '0};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_pkg::ic_lookup;
            pend_valid <= 1'b0;
            ack_seen <= 1'b0;
            valid_q <= '0;
        end else begin
            if (ready) pend_valid <= i_valid;
            case (state)
                cache_pkg::ic_lookup: if (pend_valid && !hit) state <= cache_pkg::ic_refill;
                cache_pkg::ic_refill: begin
                    if (refill_we) begin
                        ack_seen <= 1'b1;
                        valid_q[idx] <= 1'b1;
                    end else if (ack_seen && !mem_ack) begin
                        ack_seen <= 1'b0;       // link idle again
                        state <= cache_pkg::ic_respond;
                    end
                end
                default: state <= cache_pkg::ic_lookup;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_addr_ok) addr_q <= i_addr;
        if (refill_we) resp_word <= mem_rdata[word*32 +: 32];
    end

endmodule

//--- line_ram.sv
`timescale 1ns/1ps

module line_ram #(
    parameter int index_bits = 4,
    parameter int width = 32
) (
    input  logic clk,
    input  logic reset,
    input  logic [(width+7)/8-1:0] we,
    input  logic [index_bits-1:0] waddr,
    input  logic [width-1:0] wdata,
    input  logic [index_bits-1:0] raddr,
    output logic [width-1:0] rdata
);

    logic [width-1:0] mem [1 << index_bits];

    // last byte lane may be partial
    always_ff @(posedge clk) begin
        for (int i = 0; i < width; i++) begin
            if (we[i/8]) mem[waddr][i] <= wdata[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rdata <= '0;
        end else begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic clk,
    input  logic reset,
    input  logic d_req_valid,
    input  cache_pkg::mem_req_t d_req,
    output logic d_ack,
    input  logic i_req_valid,
    input  cache_pkg::mem_req_t i_req,
    output logic i_ack,
    output cache_pkg::line_t rdata,
    output logic mem_req_valid,
    output cache_pkg::mem_req_t mem_req,
    input  logic mem_ack,
    input  cache_pkg::line_t mem_rdata
);

    typedef enum logic [1:0] {
        grant_none,
        grant_d,
        grant_i
    } grant_e;

    grant_e grant, sel;
    logic ack_q;

    // dcache goes first when the link is free
    always_comb begin
        sel = grant;
        if (grant == grant_none) begin
            if (d_req_valid) sel = grant_d;
            else if (i_req_valid) sel = grant_i;
        end
    end

    assign mem_req = (sel == grant_i) ? i_req : d_req;
    assign mem_req_valid = (sel == grant_d && d_req_valid) || (sel == grant_i && i_req_valid);
    assign d_ack = mem_ack && sel == grant_d;
    assign i_ack = mem_ack && sel == grant_i;
    assign rdata = mem_rdata;   // only the acked client samples it

    always_ff @(posedge clk) begin
        if (reset) begin
            grant <= grant_none;
            ack_q <= 1'b0;
        end else begin
            ack_q <= mem_ack;
            if (grant == grant_none) begin
                grant <= sel;
            end else if (ack_q && !mem_ack) begin
                grant <= grant_none;    // handshake done
            end
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cache_top_tb -f cache_top.f

out=$(./obj_dir/Vcache_top_tb)
echo "$out"

echo "$out" | grep -qx "Test passed"

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period = 10,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule
